/* logic/pulp_pkg.sv */
// pulp soc package with bus widths, address map, register indices and host bus types
package pulp_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // address word fields
  localparam int unsigned REGION_W  = 4;
  localparam int unsigned OFFS_W    = 2;
  localparam int unsigned L2_IDX_W  = ADDR_W - REGION_W - OFFS_W;
  localparam int unsigned REG_IDX_W = 4;

  // address map, bits 15..12
  localparam logic [REGION_W-1:0] REGION_L2  = 4'd0;
  localparam logic [REGION_W-1:0] REGION_CL  = 4'd1;
  localparam logic [REGION_W-1:0] REGION_DBG = 4'd2;

  // cluster control registers
  localparam logic [REG_IDX_W-1:0] CL_FETCH_EN = 4'd0;
  localparam logic [REG_IDX_W-1:0] CL_EOC      = 4'd1;
  localparam logic [REG_IDX_W-1:0] CL_BUSY     = 4'd2;
  localparam logic [REG_IDX_W-1:0] CL_MBOX     = 4'd3;

  // debug registers
  localparam logic [REG_IDX_W-1:0] DBG_HALT   = 4'd0;
  localparam logic [REG_IDX_W-1:0] DBG_IDCODE = 4'd1;

  localparam logic [DATA_W-1:0] IDCODE = 32'h249511c3;

  typedef struct packed {
    logic [REGION_W-1:0] region;
    logic [L2_IDX_W-1:0] word_idx;
    logic [OFFS_W-1:0]   byte_off;
  } l2_addr_t;

  typedef struct packed {
    logic [REGION_W-1:0]           region;
    logic [L2_IDX_W-REG_IDX_W-1:0] rsvd;
    logic [REG_IDX_W-1:0]          reg_idx;
    logic [OFFS_W-1:0]             byte_off;
  } periph_addr_t;

  // same address word, read as memory index or as register index
  typedef union packed {
    l2_addr_t     l2;
    periph_addr_t periph;
  } soc_addr_u;

  typedef struct packed {
    logic              valid;
    logic              we;
    soc_addr_u         addr;
    logic [DATA_W-1:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic              valid;
    logic              err;
    logic [DATA_W-1:0] rdata;
  } host_rsp_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } tgt_rsp_t;

endpackage

/* logic/soc_bus.sv */
// soc bus decoding the host request region and returning one registered response
module soc_bus (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  pulp_pkg::host_req_t         req_i,
  output pulp_pkg::host_rsp_t         rsp_o,
  output logic                        l2_sel_o,
  output logic                        cl_sel_o,
  output logic                        dbg_sel_o,
  output logic                        we_o,
  output pulp_pkg::soc_addr_u         addr_o,
  output logic [pulp_pkg::DATA_W-1:0] wdata_o,
  input  pulp_pkg::tgt_rsp_t          l2_rsp_i,
  input  pulp_pkg::tgt_rsp_t          cl_rsp_i,
  input  pulp_pkg::tgt_rsp_t          dbg_rsp_i
);

  logic [pulp_pkg::REGION_W-1:0] region;
  logic                          unmapped;

  // which target answers in the next cycle
  logic valid_q;
  logic l2_q;
  logic cl_q;
  logic dbg_q;
  logic unmapped_q;

  assign region = req_i.addr.periph.region;

  assign l2_sel_o  = req_i.valid && (region == pulp_pkg::REGION_L2);
  assign cl_sel_o  = req_i.valid && (region == pulp_pkg::REGION_CL);
  assign dbg_sel_o = req_i.valid && (region == pulp_pkg::REGION_DBG);
  assign unmapped  = req_i.valid && !(l2_sel_o || cl_sel_o || dbg_sel_o);

  // request payload goes to all targets, only the strobe differs
  assign we_o    = req_i.we;
  assign addr_o  = req_i.addr;
  assign wdata_o = req_i.wdata;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q    <= 1'b0;
      l2_q       <= 1'b0;
      cl_q       <= 1'b0;
      dbg_q      <= 1'b0;
      unmapped_q <= 1'b0;
    end else begin
      valid_q    <= req_i.valid;
      l2_q       <= l2_sel_o;
      cl_q       <= cl_sel_o;
      dbg_q      <= dbg_sel_o;
      unmapped_q <= unmapped;
    end
  end

  // response merge, zero when idle
  always_comb begin
    rsp_o       = '0;
    rsp_o.valid = valid_q;
    if (l2_q) begin
      rsp_o.rdata = l2_rsp_i.rdata;
      rsp_o.err   = l2_rsp_i.err;
    end else if (cl_q) begin
      rsp_o.rdata = cl_rsp_i.rdata;
      rsp_o.err   = cl_rsp_i.err;
    end else if (dbg_q) begin
      rsp_o.rdata = dbg_rsp_i.rdata;
      rsp_o.err   = dbg_rsp_i.err;
    end else if (unmapped_q) begin
      // nothing decoded this address
      rsp_o.err = 1'b1;
    end
  end

endmodule

/* logic/l2_mem.sv */
// l2 scratchpad, single port word memory with one cycle read latency
module l2_mem #(
  parameter int unsigned L2_WORDS = 256
) (
  input  logic                        clk_i,
  input  logic                        sel_i,
  input  logic                        we_i,
  input  pulp_pkg::soc_addr_u         addr_i,
  input  logic [pulp_pkg::DATA_W-1:0] wdata_i,
  output pulp_pkg::tgt_rsp_t          rsp_o
);

  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  logic [pulp_pkg::DATA_W-1:0] mem_q [L2_WORDS];
  logic [IDX_W-1:0]            idx;

  // word index wraps at the memory size
  assign idx = IDX_W'(32'(addr_i.l2.word_idx) % L2_WORDS);

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      if (we_i) begin
        mem_q[idx] <= wdata_i;
        rsp_o      <= '{rdata: '0, err: 1'b0};
      end else begin
        rsp_o <= '{rdata: mem_q[idx], err: 1'b0};
      end
    end
  end

endmodule

/* logic/cluster_ctrl.sv */
// cluster control registers for fetch enable, end of computation, busy and mailbox events
module cluster_ctrl #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic                        sel_i,
  input  logic                        we_i,
  input  pulp_pkg::soc_addr_u         addr_i,
  input  logic [pulp_pkg::DATA_W-1:0] wdata_i,
  output pulp_pkg::tgt_rsp_t          rsp_o,
  output logic [N_CLUSTERS-1:0]       cl_fetch_en_o,
  input  logic [N_CLUSTERS-1:0]       cl_eoc_i,
  input  logic [N_CLUSTERS-1:0]       cl_busy_i,
  input  logic                        mailbox_evt_i
);

  logic [N_CLUSTERS-1:0]       fetch_en_q;
  logic [N_CLUSTERS-1:0]       eoc_q;
  logic [pulp_pkg::DATA_W-1:0] mbox_q;
  logic [pulp_pkg::DATA_W-1:0] rd_data;
  logic                        idx_err;
  logic                        wr;
  logic [N_CLUSTERS-1:0]       eoc_clr;

  assign wr            = sel_i && we_i;
  assign cl_fetch_en_o = fetch_en_q;

  always_comb begin
    rd_data = '0;
    idx_err = 1'b0;
    case (addr_i.periph.reg_idx)
      pulp_pkg::CL_FETCH_EN: rd_data = 32'(fetch_en_q);
      pulp_pkg::CL_EOC:      rd_data = 32'(eoc_q);
      pulp_pkg::CL_BUSY:     rd_data = 32'(cl_busy_i);
      pulp_pkg::CL_MBOX:     rd_data = mbox_q;
      default:               idx_err = 1'b1;
    endcase
  end

  // write one to clear, a pulse in the same cycle wins
  assign eoc_clr = (wr && addr_i.periph.reg_idx == pulp_pkg::CL_EOC) ?
                   wdata_i[N_CLUSTERS-1:0] : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_en_q <= '0;
      eoc_q      <= '0;
      mbox_q     <= '0;
    end else begin
      if (wr && addr_i.periph.reg_idx == pulp_pkg::CL_FETCH_EN) begin
        fetch_en_q <= wdata_i[N_CLUSTERS-1:0];
      end
      eoc_q <= (eoc_q & ~eoc_clr) | cl_eoc_i;
      if (wr && addr_i.periph.reg_idx == pulp_pkg::CL_MBOX) begin
        mbox_q <= '0;
      end else if (mailbox_evt_i) begin
        mbox_q <= mbox_q + 32'd1;
      end
    end
  end

  // writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_o.err   <= idx_err;
      rsp_o.rdata <= (we_i || idx_err) ? '0 : rd_data;
    end
  end

endmodule

/* logic/debug_regs.sv */
// debug registers holding per hart halt requests and a fixed id code
module debug_regs #(
  parameter int unsigned N_CLUSTERS = 2,
  parameter int unsigned N_CORES    = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           sel_i,
  input  logic                           we_i,
  input  pulp_pkg::soc_addr_u            addr_i,
  input  logic [pulp_pkg::DATA_W-1:0]    wdata_i,
  output pulp_pkg::tgt_rsp_t             rsp_o,
  output logic [N_CLUSTERS*N_CORES-1:0]  core_debug_req_o
);

  // hart k is cluster * N_CORES + core
  localparam int unsigned N_HARTS = N_CLUSTERS * N_CORES;

  logic [N_HARTS-1:0]          halt_q;
  logic [pulp_pkg::DATA_W-1:0] rd_data;
  logic                        idx_err;

  assign core_debug_req_o = halt_q;

  always_comb begin
    rd_data = '0;
    idx_err = 1'b0;
    case (addr_i.periph.reg_idx)
      pulp_pkg::DBG_HALT:   rd_data = 32'(halt_q);
      pulp_pkg::DBG_IDCODE: rd_data = pulp_pkg::IDCODE;
      default:              idx_err = 1'b1;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      halt_q <= '0;
    end else if (sel_i && we_i && addr_i.periph.reg_idx == pulp_pkg::DBG_HALT) begin
      halt_q <= wdata_i[N_HARTS-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (sel_i) begin
      rsp_o.err   <= idx_err;
      rsp_o.rdata <= (we_i || idx_err) ? '0 : rd_data;
    end
  end

endmodule

/* logic/pulp_soc.sv */
// pulp soc top level joining host bus, l2 memory, cluster control and debug registers
module pulp_soc #(
  parameter int unsigned N_CLUSTERS = 2,
  parameter int unsigned N_CORES    = 4,
  parameter int unsigned L2_WORDS   = 256
) (
  input  logic                          clk_i,
  input  logic                          rst_i,
  input  pulp_pkg::host_req_t           req_i,
  output pulp_pkg::host_rsp_t           rsp_o,
  output logic [N_CLUSTERS-1:0]         cl_fetch_en_o,
  input  logic [N_CLUSTERS-1:0]         cl_eoc_i,
  input  logic [N_CLUSTERS-1:0]         cl_busy_i,
  input  logic                          mailbox_evt_i,
  output logic [N_CLUSTERS*N_CORES-1:0] core_debug_req_o
);

  logic                        l2_sel;
  logic                        cl_sel;
  logic                        dbg_sel;
  logic                        we;
  pulp_pkg::soc_addr_u         addr;
  logic [pulp_pkg::DATA_W-1:0] wdata;
  pulp_pkg::tgt_rsp_t          l2_rsp;
  pulp_pkg::tgt_rsp_t          cl_rsp;
  pulp_pkg::tgt_rsp_t          dbg_rsp;

  soc_bus i_soc_bus (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req_i     (req_i),
    .rsp_o     (rsp_o),
    .l2_sel_o  (l2_sel),
    .cl_sel_o  (cl_sel),
    .dbg_sel_o (dbg_sel),
    .we_o      (we),
    .addr_o    (addr),
    .wdata_o   (wdata),
    .l2_rsp_i  (l2_rsp),
    .cl_rsp_i  (cl_rsp),
    .dbg_rsp_i (dbg_rsp)
  );

  l2_mem #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_mem (
    .clk_i   (clk_i),
    .sel_i   (l2_sel),
    .we_i    (we),
    .addr_i  (addr),
    .wdata_i (wdata),
    .rsp_o   (l2_rsp)
  );

  cluster_ctrl #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_cluster_ctrl (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .sel_i         (cl_sel),
    .we_i          (we),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .rsp_o         (cl_rsp),
    .cl_fetch_en_o (cl_fetch_en_o),
    .cl_eoc_i      (cl_eoc_i),
    .cl_busy_i     (cl_busy_i),
    .mailbox_evt_i (mailbox_evt_i)
  );

  debug_regs #(
    .N_CLUSTERS (N_CLUSTERS),
    .N_CORES    (N_CORES)
  ) i_debug_regs (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .sel_i            (dbg_sel),
    .we_i             (we),
    .addr_i           (addr),
    .wdata_i          (wdata),
    .rsp_o            (dbg_rsp),
    .core_debug_req_o (core_debug_req_o)
  );

endmodule

/* sim/pulp_soc_checker.sv */
// bound assertions on host response timing, error data and reset state of the pulp soc
module pulp_soc_checker #(
  parameter int unsigned N_CLUSTERS = 2
) (
  input logic                  clk_i,
  input logic                  rst_i,
  input pulp_pkg::host_req_t   req_i,
  input pulp_pkg::host_rsp_t   rsp_i,
  input logic [N_CLUSTERS-1:0] cl_fetch_en_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // one response per request, exactly one cycle later
  rsp_follows_req: assert property (
    @(posedge clk_i) disable iff (rst_i) rsp_i.valid == $past(req_i.valid)
  ) else $error("host response valid does not follow request valid by one cycle");

  // error responses carry no data
  err_no_data: assert property (
    @(posedge clk_i) disable iff (rst_i) rsp_i.err |-> rsp_i.rdata == '0
  ) else $error("error response with nonzero read data");

  // clusters stay parked out of reset
  fetch_en_reset: assert property (
    @(posedge clk_i) rst_i |=> cl_fetch_en_i == '0
  ) else $error("fetch enable not cleared one cycle after reset");

endmodule

/* sim/tb_pulp_soc.sv */
// directed testbench for the pulp soc host bus, cluster pins and debug requests
module tb_pulp_soc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned N_CLUSTERS  = 2;
  localparam int unsigned N_CORES     = 4;
  localparam int unsigned L2_WORDS    = 256;
  // tests take roughly 200 cycles
  localparam int unsigned TEST_CYCLES = 200;
  localparam int unsigned MAX_CYCLES  = 10 * TEST_CYCLES;

  logic                          clk_i;
  logic                          rst_i;
  pulp_pkg::host_req_t           req_i;
  pulp_pkg::host_rsp_t           rsp_o;
  logic [N_CLUSTERS-1:0]         cl_fetch_en_o;
  logic [N_CLUSTERS-1:0]         cl_eoc_i;
  logic [N_CLUSTERS-1:0]         cl_busy_i;
  logic                          mailbox_evt_i;
  logic [N_CLUSTERS*N_CORES-1:0] core_debug_req_o;

  // response expected for the request in flight
  logic        pending;
  logic        exp_err;
  logic [31:0] exp_rdata;
  string       exp_tag;

  logic [31:0]     l2_ref [L2_WORDS];
  logic [9:0]      l2_idx [16];
  logic [7:0]      halt_pat;
  int unsigned     cycles;

  pulp_soc #(
    .N_CLUSTERS (N_CLUSTERS),
    .N_CORES    (N_CORES),
    .L2_WORDS   (L2_WORDS)
  ) uut (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .req_i            (req_i),
    .rsp_o            (rsp_o),
    .cl_fetch_en_o    (cl_fetch_en_o),
    .cl_eoc_i         (cl_eoc_i),
    .cl_busy_i        (cl_busy_i),
    .mailbox_evt_i    (mailbox_evt_i),
    .core_debug_req_o (core_debug_req_o)
  );

  bind pulp_soc pulp_soc_checker #(
    .N_CLUSTERS (N_CLUSTERS)
  ) i_checker (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .rsp_i         (rsp_o),
    .cl_fetch_en_i (cl_fetch_en_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_i);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        $display("timeout, tests still running after %0d cycles", cycles);
        $display("sim failed");
        $fatal(1, "cycle limit reached");
      end
    end
  end

  function automatic logic [15:0] l2_addr(input logic [9:0] idx);
    return {4'd0, idx, 2'b00};
  endfunction

  function automatic logic [15:0] reg_addr(input logic [3:0] region, input logic [3:0] idx);
    return {region, 6'd0, idx, 2'b00};
  endfunction

  // l2 wraps the word index at its size
  function automatic logic [7:0] ref_slot(input logic [9:0] idx);
    return 8'(32'(idx) % L2_WORDS);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
      $display("sim failed");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic collect_rsp();
    check_eq({exp_tag, " rsp_o.valid"}, 32'(rsp_o.valid), 32'(pending));
    if (pending) begin
      check_eq({exp_tag, " rsp_o.err"}, 32'(rsp_o.err), 32'(exp_err));
      check_eq({exp_tag, " rsp_o.rdata"}, rsp_o.rdata, exp_rdata);
    end
  endtask

  // drive one request and check the previous response at the same falling edge
  task automatic issue(input logic we, input logic [15:0] addr, input logic [31:0] wdata,
                       input logic err, input logic [31:0] rdata, input string tag);
    @(negedge clk_i);
    collect_rsp();
    req_i.valid = 1'b1;
    req_i.we    = we;
    req_i.addr  = addr;
    req_i.wdata = wdata;
    pending     = 1'b1;
    exp_err     = err;
    // writes and errors return zero data
    exp_rdata   = (we || err) ? 32'd0 : rdata;
    exp_tag     = tag;
  endtask

  task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
                            input logic err, input string tag);
    issue(1'b1, addr, data, err, 32'd0, tag);
  endtask

  task automatic read_word(input logic [15:0] addr, input logic [31:0] exp,
                           input logic err, input string tag);
    issue(1'b0, addr, $urandom, err, exp, tag);
  endtask

  task automatic idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk_i);
      collect_rsp();
      req_i   = '0;
      pending = 1'b0;
      exp_tag = "idle";
    end
  endtask

  task automatic check_reset();
    idle(1);
    check_eq("cl_fetch_en_o", 32'(cl_fetch_en_o), 32'd0);
    check_eq("core_debug_req_o", 32'(core_debug_req_o), 32'd0);
    read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_EOC), 32'd0, 1'b0, "eoc after reset");
    read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_MBOX), 32'd0, 1'b0, "mbox after reset");
    idle(1);
  endtask

  task automatic test_l2();
    logic [31:0] data;
    for (int i = 0; i < 16; i++) begin
      l2_idx[i] = 10'($urandom);
      data = $urandom;
      l2_ref[ref_slot(l2_idx[i])] = data;
      write_word(l2_addr(l2_idx[i]), data, 1'b0, "l2 write");
    end
    for (int i = 0; i < 16; i++) begin
      read_word(l2_addr(l2_idx[i]), l2_ref[ref_slot(l2_idx[i])], 1'b0, "l2 read");
    end
    idle(1);
  endtask

  task automatic test_fetch_en();
    for (int p = 1; p <= 2; p++) begin
      write_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_FETCH_EN), 32'(p), 1'b0,
                 "fetch_en write");
      idle(1);
      check_eq("cl_fetch_en_o", 32'(cl_fetch_en_o), 32'(p));
      read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_FETCH_EN), 32'(p), 1'b0,
                "fetch_en read");
    end
    idle(1);
  endtask

  task automatic pulse_eoc(input logic [N_CLUSTERS-1:0] mask);
    idle(1);
    cl_eoc_i = mask;
    idle(1);
    cl_eoc_i = '0;
    // flag must stay set afterwards
    idle(3);
  endtask

  task automatic test_cluster_events();
    logic [15:0] eoc;
    eoc = reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_EOC);
    pulse_eoc(2'b01);
    read_word(eoc, 32'h1, 1'b0, "eoc read");
    pulse_eoc(2'b10);
    read_word(eoc, 32'h3, 1'b0, "eoc read");
    write_word(eoc, 32'h1, 1'b0, "eoc clear");
    read_word(eoc, 32'h2, 1'b0, "eoc after clear");
    write_word(eoc, 32'h2, 1'b0, "eoc clear");
    read_word(eoc, 32'h0, 1'b0, "eoc after clear");
    idle(1);
    cl_busy_i = 2'b10;
    read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_BUSY), 32'h2, 1'b0, "busy read");
    idle(1);
    cl_busy_i = 2'b01;
    read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_BUSY), 32'h1, 1'b0, "busy read");
    idle(1);
  endtask

  task automatic test_mailbox();
    int unsigned n;
    logic [15:0] mbox;
    n = 3 + ($urandom % 8);
    mbox = reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_MBOX);
    mailbox_evt_i = 1'b1;
    idle(n);
    mailbox_evt_i = 1'b0;
    read_word(mbox, n, 1'b0, "mbox count");
    write_word(mbox, $urandom, 1'b0, "mbox clear");
    read_word(mbox, 32'd0, 1'b0, "mbox after clear");
    idle(1);
  endtask

  task automatic test_debug();
    halt_pat = 8'($urandom) | 8'h81;
    write_word(reg_addr(pulp_pkg::REGION_DBG, pulp_pkg::DBG_HALT), 32'(halt_pat), 1'b0,
               "halt write");
    idle(1);
    check_eq("core_debug_req_o", 32'(core_debug_req_o), 32'(halt_pat));
    read_word(reg_addr(pulp_pkg::REGION_DBG, pulp_pkg::DBG_HALT), 32'(halt_pat), 1'b0,
              "halt read");
    read_word(reg_addr(pulp_pkg::REGION_DBG, pulp_pkg::DBG_IDCODE), 32'h249511c3, 1'b0,
              "idcode read");
    idle(1);
  endtask

  task automatic test_errors();
    // live eoc flags and mailbox count that a stray write would disturb
    pulse_eoc(2'b11);
    mailbox_evt_i = 1'b1;
    idle(2);
    mailbox_evt_i = 1'b0;
    read_word(reg_addr(4'd3, 4'd0), 32'd0, 1'b1, "unmapped read");
    // aliases an l2 word that must stay intact
    write_word({4'd3, l2_idx[0], 2'b00}, $urandom, 1'b1, "unmapped write");
    read_word(reg_addr(pulp_pkg::REGION_CL, 4'd5), 32'd0, 1'b1, "cluster idx 5 read");
    write_word(reg_addr(pulp_pkg::REGION_CL, 4'd5), 32'hffff_ffff, 1'b1, "cluster idx 5 write");
    read_word(reg_addr(pulp_pkg::REGION_DBG, 4'd2), 32'd0, 1'b1, "debug idx 2 read");
    write_word(reg_addr(pulp_pkg::REGION_DBG, 4'd2), 32'hffff_ffff, 1'b1, "debug idx 2 write");
    idle(1);
    check_eq("cl_fetch_en_o", 32'(cl_fetch_en_o), 32'h2);
    check_eq("core_debug_req_o", 32'(core_debug_req_o), 32'(halt_pat));
    read_word(l2_addr(l2_idx[0]), l2_ref[ref_slot(l2_idx[0])], 1'b0, "l2 after errors");
    read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_MBOX), 32'd2, 1'b0, "mbox after errors");
    read_word(reg_addr(pulp_pkg::REGION_CL, pulp_pkg::CL_EOC), 32'h3, 1'b0, "eoc after errors");
    idle(1);
  endtask

  initial begin
    void'($urandom(32'hb0dc));
    rst_i         = 1'b1;
    req_i         = '0;
    cl_eoc_i      = '0;
    cl_busy_i     = '0;
    mailbox_evt_i = 1'b0;
    pending       = 1'b0;
    exp_err       = 1'b0;
    exp_rdata     = '0;
    exp_tag       = "idle";
    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;
    check_reset();
    test_l2();
    test_fetch_en();
    test_cluster_events();
    test_mailbox();
    test_debug();
    test_errors();
    $display("sim passed");
    $finish;
  end

endmodule

/* filelist.f */
logic/pulp_pkg.sv
logic/soc_bus.sv
logic/l2_mem.sv
logic/cluster_ctrl.sv
logic/debug_regs.sv
logic/pulp_soc.sv
sim/pulp_soc_checker.sv
sim/tb_pulp_soc.sv

/* Makefile */
# Verilator flow for the pulp soc testbench

VERILATOR ?= verilator
TOP       ?= tb_pulp_soc
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
